// File: logic/sdram_tester_pkg.sv
package sdram_tester_pkg;

    localparam int ADDR_WIDTH      = 27;                           // Three switch chunks
    localparam int SWITCH_WIDTH    = 10;
    localparam int MAX_BURST_LIMIT = 16;                           // Buffer depth in the structs
    localparam int SIZE_WIDTH      = $clog2(MAX_BURST_LIMIT + 1);  // Holds 1..MAX_BURST_LIMIT
    localparam int INDEX_WIDTH     = $clog2(MAX_BURST_LIMIT);      // Byte index within a burst

    // Operator-driven sequence, same order as the original tester
    typedef enum logic [3:0] {
        idle     = 4'h0,
        address1 = 4'h1,  // Bits 9:0
        address2 = 4'h2,  // Bits 19:10
        address3 = 4'h3,  // Bits 26:20
        op_size  = 4'h4,
        op_mode  = 4'h5,
        rd_start = 4'h6,
        rd_wait  = 4'h7,
        rd_mode  = 4'h8,  // Stepping through the display
        pre_wr   = 4'h9,  // Data entry
        wr_start = 4'ha,
        wr_wait  = 4'hb
    } tester_state_t;

    typedef enum logic [1:0] {
        chunk_low  = 2'd0,
        chunk_mid  = 2'd1,
        chunk_high = 2'd2
    } addr_chunk_t;

    typedef logic [7:0] byte_t;

    // Request held steady by the datapath while the memory works on it
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]            addr;
        logic [SIZE_WIDTH-1:0]            size;     // 1..MAX_BURST
        byte_t [MAX_BURST_LIMIT-1:0]      wr_data;  // Entry i goes to addr + i
    } mem_request_t;

    // One byte per cycle back from a read
    typedef struct packed {
        logic                   valid;
        logic [INDEX_WIDTH-1:0] index;
        byte_t                  data;
    } read_beat_t;

endpackage

// File: logic/sdram_tester_uc.sv
`timescale 1ns/1ps

module sdram_tester_uc import sdram_tester_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        switch_mode,  // 1 selects write
    input  logic        enter,        // One-cycle strobe from the operator
    input  logic        op_end,
    input  logic        busy,
    output logic        rd_en,
    output logic        wr_en,
    output logic        op_rst,
    output logic        addr_en,
    output addr_chunk_t addr_sel,
    output logic        size_en,
    output logic        wr_data_en,
    output logic        cnt_en,
    output logic        cnt_rst,
    output logic        show_read,
    output logic        tester_idle
);

    tester_state_t state;
    tester_state_t next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;  // Hold unless a condition below fires
        rd_en      = 1'b0;
        wr_en      = 1'b0;
        op_rst     = 1'b0;
        addr_en    = 1'b0;
        addr_sel   = chunk_low;
        size_en    = 1'b0;
        wr_data_en = 1'b0;
        cnt_en     = 1'b0;
        cnt_rst    = 1'b0;
        case (state)
            idle: begin
                if (enter) begin
                    next_state = address1;
                end
            end
            address1: begin
                if (enter) begin
                    addr_en    = 1'b1;  // Low chunk is the default select
                    next_state = address2;
                end
            end
            address2: begin
                if (enter) begin
                    addr_en    = 1'b1;
                    addr_sel   = chunk_mid;
                    next_state = address3;
                end
            end
            address3: begin
                if (enter) begin
                    addr_en    = 1'b1;
                    addr_sel   = chunk_high;
                    next_state = op_size;
                end
            end
            op_size: begin
                if (enter) begin
                    size_en    = 1'b1;
                    next_state = op_mode;
                end
            end
            op_mode: begin
                cnt_rst = 1'b1;  // Data entry starts at byte 0
                if (enter) begin
                    if (switch_mode) begin
                        next_state = pre_wr;
                    end else begin
                        next_state = rd_start;
                    end
                end
            end
            rd_start: begin
                rd_en = 1'b1;  // Held until the memory takes it
                if (busy) begin
                    next_state = rd_wait;
                end
            end
            rd_wait: begin
                cnt_rst = 1'b1;  // Display starts at byte 0
                if (!busy) begin
                    op_rst     = 1'b1;  // Frees the memory for the next request
                    next_state = rd_mode;
                end
            end
            rd_mode: begin
                cnt_en = enter;  // Next byte on the display
                if (enter && op_end) begin
                    next_state = idle;
                end
            end
            pre_wr: begin
                wr_data_en = enter;
                cnt_en     = enter;
                if (enter && op_end) begin
                    next_state = wr_start;
                end
            end
            wr_start: begin
                wr_en = 1'b1;
                if (busy) begin
                    next_state = wr_wait;
                end
            end
            wr_wait: begin
                if (!busy) begin
                    op_rst     = 1'b1;
                    next_state = idle;
                end
            end
            default: begin
                next_state = idle;  // Unreachable encodings
            end
        endcase
    end

    assign show_read   = (state == rd_mode);
    assign tester_idle = (state == idle);

endmodule

// File: logic/sdram_tester_df.sv
`timescale 1ns/1ps

module sdram_tester_df import sdram_tester_pkg::*; #(
    parameter int MAX_BURST = 8
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [SWITCH_WIDTH-1:0] switches,
    input  logic                    addr_en,
    input  addr_chunk_t             addr_sel,
    input  logic                    size_en,
    input  logic                    wr_data_en,
    input  logic                    cnt_en,
    input  logic                    cnt_rst,
    input  read_beat_t              read_beat,
    output mem_request_t            request,
    output logic                    op_end,
    output byte_t                   display
);

    localparam int HIGH_CHUNK = ADDR_WIDTH - 2 * SWITCH_WIDTH;  // 7 bits

    logic [ADDR_WIDTH-1:0]       address;
    logic [SIZE_WIDTH-1:0]       size;
    logic [SIZE_WIDTH-1:0]       size_next;
    logic [SIZE_WIDTH-1:0]       counter;
    logic [INDEX_WIDTH-1:0]      byte_index;
    byte_t [MAX_BURST_LIMIT-1:0] wr_buffer;
    byte_t [MAX_BURST_LIMIT-1:0] rd_buffer;

    // Address built from three switch chunks
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            address <= '0;
        end else if (addr_en) begin
            case (addr_sel)
                chunk_low:  address[SWITCH_WIDTH-1:0] <= switches;
                chunk_mid:  address[2*SWITCH_WIDTH-1:SWITCH_WIDTH] <= switches;
                chunk_high: address[ADDR_WIDTH-1:2*SWITCH_WIDTH] <= switches[HIGH_CHUNK-1:0];
                default:    address <= address;
            endcase
        end
    end

    // Zero means one byte, anything past the limit means a full burst
    always_comb begin
        if (switches == '0) begin
            size_next = SIZE_WIDTH'(1);
        end else if (switches > SWITCH_WIDTH'(MAX_BURST)) begin
            size_next = SIZE_WIDTH'(MAX_BURST);
        end else begin
            size_next = switches[SIZE_WIDTH-1:0];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            size <= '0;
        end else if (size_en) begin
            size <= size_next;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            counter <= '0;
        end else if (cnt_rst) begin
            counter <= '0;
        end else if (cnt_en) begin
            counter <= counter + SIZE_WIDTH'(1);
        end
    end

    assign byte_index = counter[INDEX_WIDTH-1:0];
    assign op_end     = (counter == size - SIZE_WIDTH'(1));  // Last byte of the burst

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_buffer <= '0;
        end else if (wr_data_en) begin
            wr_buffer[byte_index] <= switches[7:0];
        end
    end

    // Beats arrive with their own index
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_buffer <= '0;
        end else if (read_beat.valid) begin
            rd_buffer[read_beat.index] <= read_beat.data;
        end
    end

    always_comb begin
        request.addr    = address;
        request.size    = size;
        request.wr_data = wr_buffer;
    end

    assign display = rd_buffer[byte_index];

endmodule

// File: logic/burst_memory.sv
`timescale 1ns/1ps

module burst_memory import sdram_tester_pkg::*; #(
    parameter int MAX_BURST      = 8,
    parameter int MEM_ADDR_WIDTH = 12,
    parameter int ACCESS_LATENCY = 3
) (
    input  logic         clock,
    input  logic         reset,
    input  logic         rd_en,
    input  logic         wr_en,
    input  logic         op_rst,
    input  mem_request_t request,
    output logic         busy,
    output read_beat_t   read_beat
);

    localparam int MEM_DEPTH = 2 ** MEM_ADDR_WIDTH;
    localparam int CNT_WIDTH = $clog2(ACCESS_LATENCY + MAX_BURST + 1);

    byte_t mem [MEM_DEPTH] = '{default: 8'h00};

    mem_request_t              active;        // Request captured at accept
    logic                      active_write;
    logic                      done;          // Set at the end, cleared by op_rst
    logic [CNT_WIDTH-1:0]      cycle_cnt;
    logic [CNT_WIDTH-1:0]      last_cycle;
    logic                      accept;
    logic                      in_transfer;
    logic [INDEX_WIDTH-1:0]    beat_index;
    logic [MEM_ADDR_WIDTH-1:0] beat_addr;

    assign accept      = (rd_en || wr_en) && !busy && !done;
    assign last_cycle  = CNT_WIDTH'(ACCESS_LATENCY) + CNT_WIDTH'(active.size) - CNT_WIDTH'(1);
    assign in_transfer = busy && (cycle_cnt >= CNT_WIDTH'(ACCESS_LATENCY));
    assign beat_index  = INDEX_WIDTH'(cycle_cnt - CNT_WIDTH'(ACCESS_LATENCY));

    // Upper address bits alias, burst wraps at the top
    assign beat_addr = active.addr[MEM_ADDR_WIDTH-1:0] + MEM_ADDR_WIDTH'(beat_index);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy         <= 1'b0;
            done         <= 1'b0;
            cycle_cnt    <= '0;
            active_write <= 1'b0;
        end else if (accept) begin
            busy         <= 1'b1;
            cycle_cnt    <= '0;
            active_write <= wr_en;
        end else if (busy) begin
            if (cycle_cnt == last_cycle) begin
                busy <= 1'b0;  // Falls right after the last byte
                done <= 1'b1;
            end
            cycle_cnt <= cycle_cnt + CNT_WIDTH'(1);
        end else if (op_rst) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            active <= request;
        end
    end

    // One byte per cycle after the latency
    always_ff @(posedge clock) begin
        if (in_transfer && active_write) begin
            mem[beat_addr] <= active.wr_data[beat_index];
        end
    end

    always_comb begin
        read_beat.valid = in_transfer && !active_write;
        read_beat.index = beat_index;
        read_beat.data  = mem[beat_addr];
    end

endmodule

// File: logic/sdram_tester.sv
`timescale 1ns/1ps

module sdram_tester import sdram_tester_pkg::*; #(
    parameter int MAX_BURST      = 8,
    parameter int MEM_ADDR_WIDTH = 12,
    parameter int ACCESS_LATENCY = 3
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [SWITCH_WIDTH-1:0] switches,
    input  logic                    enter,
    output byte_t                   display,
    output logic                    show_read,
    output logic                    tester_idle,
    output logic                    busy
);

    logic         rd_en;
    logic         wr_en;
    logic         op_rst;
    logic         addr_en;
    addr_chunk_t  addr_sel;
    logic         size_en;
    logic         wr_data_en;
    logic         cnt_en;
    logic         cnt_rst;
    logic         op_end;
    mem_request_t request;
    read_beat_t   read_beat;

    sdram_tester_uc uc_i (
        .clock       (clock),
        .reset       (reset),
        .switch_mode (switches[0]),  // Write when set
        .enter       (enter),
        .op_end      (op_end),
        .busy        (busy),
        .rd_en       (rd_en),
        .wr_en       (wr_en),
        .op_rst      (op_rst),
        .addr_en     (addr_en),
        .addr_sel    (addr_sel),
        .size_en     (size_en),
        .wr_data_en  (wr_data_en),
        .cnt_en      (cnt_en),
        .cnt_rst     (cnt_rst),
        .show_read   (show_read),
        .tester_idle (tester_idle)
    );

    sdram_tester_df #(
        .MAX_BURST (MAX_BURST)
    ) df_i (
        .clock      (clock),
        .reset      (reset),
        .switches   (switches),
        .addr_en    (addr_en),
        .addr_sel   (addr_sel),
        .size_en    (size_en),
        .wr_data_en (wr_data_en),
        .cnt_en     (cnt_en),
        .cnt_rst    (cnt_rst),
        .read_beat  (read_beat),
        .request    (request),
        .op_end     (op_end),
        .display    (display)
    );

    burst_memory #(
        .MAX_BURST      (MAX_BURST),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
        .ACCESS_LATENCY (ACCESS_LATENCY)
    ) mem_i (
        .clock     (clock),
        .reset     (reset),
        .rd_en     (rd_en),
        .wr_en     (wr_en),
        .op_rst    (op_rst),
        .request   (request),
        .busy      (busy),
        .read_beat (read_beat)
    );

endmodule

// File: verification/sdram_tester_assertions.sv
`timescale 1ns/1ps

module sdram_tester_assertions (
    input logic clock,
    input logic reset,
    input logic rd_en,
    input logic wr_en,
    input logic op_rst,
    input logic busy,
    input logic tester_idle
);

    int failure_count = 0;  // Picked up by the testbench summary

    read_write_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(rd_en && wr_en)
    ) else begin
        $error("rd_en and wr_en high in the same cycle");
        failure_count++;
    end

    // Memory done flag is cleared right after the access ends
    op_rst_after_busy: assert property (
        @(posedge clock) disable iff (reset) op_rst |-> (!busy && $past(busy))
    ) else begin
        $error("op_rst high outside the cycle after busy fell");
        failure_count++;
    end

    idle_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> tester_idle
    ) else begin
        $error("control unit not idle after reset");
        failure_count++;
    end

endmodule

bind sdram_tester_uc sdram_tester_assertions assertions_i (
    .clock       (clock),
    .reset       (reset),
    .rd_en       (rd_en),
    .wr_en       (wr_en),
    .op_rst      (op_rst),
    .busy        (busy),
    .tester_idle (tester_idle)
);

// File: verification/sdram_tester_tb.sv
`timescale 1ns/1ps

module sdram_tester_tb import sdram_tester_pkg::*; ();

    localparam int MEM_ADDR_WIDTH = 12;  // Same as the DUT defaults
    localparam int MEM_DEPTH      = 2 ** MEM_ADDR_WIDTH;
    localparam int MAX_BURST      = 8;
    localparam int WAIT_LIMIT     = 200;  // Cycles

    logic                    clock;
    logic                    reset;
    logic [SWITCH_WIDTH-1:0] switches;
    logic                    enter;
    byte_t                   display;
    logic                    show_read;
    logic                    tester_idle;
    logic                    busy;

    byte_t ref_mem [MEM_DEPTH] = '{default: 8'h00};  // Expected memory contents
    byte_t data_buf [MAX_BURST_LIMIT];                // Bytes for the next write
    int    seed = 32'hc45b;
    int    error_count;
    int    check_count;
    int    tests_run;
    int    tests_failed;
    int    test_start_errors;
    bit    timed_out;
    logic  check_armed;
    byte_t check_expected;

    sdram_tester dut_i (
        .clock       (clock),
        .reset       (reset),
        .switches    (switches),
        .enter       (enter),
        .display     (display),
        .show_read   (show_read),
        .tester_idle (tester_idle),
        .busy        (busy)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic int clamp_size(input logic [SWITCH_WIDTH-1:0] sw);
        int value;
        value = int'(sw);
        if (value == 0) return 1;
        if (value > MAX_BURST) return MAX_BURST;
        return value;
    endfunction

    // Higher bits alias, offsets wrap modulo the memory size
    function automatic int model_location(input logic [ADDR_WIDTH-1:0] addr, input int offset);
        return (int'(addr % MEM_DEPTH) + offset) % MEM_DEPTH;
    endfunction

    // Byte the display should show for burst position index
    function automatic byte_t expected_byte(input logic [ADDR_WIDTH-1:0] addr, input int index);
        return ref_mem[model_location(addr, index)];
    endfunction

    function automatic void write_model(input logic [ADDR_WIDTH-1:0] addr, input int n);
        for (int i = 0; i < n; i++) begin
            ref_mem[model_location(addr, i)] = data_buf[INDEX_WIDTH'(i)];
        end
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // Display sampled before the edge that advances the counter
    always @(posedge clock) begin
        if (check_armed) begin
            check("display", 32'(display), 32'(check_expected));
        end
    end

    task automatic press(input logic [SWITCH_WIDTH-1:0] value);
        @(negedge clock);
        switches = value;
        enter    = 1'b1;
        @(negedge clock);
        enter    = 1'b0;
    endtask

    task automatic wait_for(input string what, input bit want_read);
        int cycles;
        cycles = 0;
        while (!(want_read ? show_read : tester_idle) && !timed_out) begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout: %s never went high", what);
                timed_out = 1'b1;
                error_count++;
            end
        end
    endtask

    task automatic load_setup(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [SWITCH_WIDTH-1:0] size_sw, input bit write);
        press('0);  // Leaves idle
        press(addr[9:0]);
        press(addr[19:10]);
        press({3'b000, addr[26:20]});
        press(size_sw);
        press(write ? 10'd1 : 10'd0);
    endtask

    task automatic do_write(input logic [ADDR_WIDTH-1:0] addr,
                            input logic [SWITCH_WIDTH-1:0] size_sw);
        int n;
        n = clamp_size(size_sw);
        if (timed_out) return;
        load_setup(addr, size_sw, 1'b1);
        for (int i = 0; i < n; i++) begin
            press({2'b00, data_buf[INDEX_WIDTH'(i)]});
        end
        wait_for("tester_idle", 1'b0);
        write_model(addr, n);
    endtask

    task automatic do_read(input logic [ADDR_WIDTH-1:0] addr,
                           input logic [SWITCH_WIDTH-1:0] size_sw);
        int n;
        n = clamp_size(size_sw);
        if (timed_out) return;
        load_setup(addr, size_sw, 1'b0);
        wait_for("show_read", 1'b1);
        if (timed_out) return;
        for (int i = 0; i < n; i++) begin
            @(negedge clock);
            enter          = 1'b1;
            check_expected = expected_byte(addr, i);
            check_armed    = 1'b1;
            @(negedge clock);
            enter          = 1'b0;
            check_armed    = 1'b0;
        end
        wait_for("tester_idle", 1'b0);
        check("show_read", 32'(show_read), 32'd0);  // Display mode is over
    endtask

    task automatic fill_pattern(input byte_t base);
        for (int i = 0; i < MAX_BURST_LIMIT; i++) begin
            data_buf[INDEX_WIDTH'(i)] = base + 8'(i * 29);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < MAX_BURST_LIMIT; i++) begin
            data_buf[INDEX_WIDTH'(i)] = 8'($random(seed));
        end
    endtask

    task automatic random_ops(input int count);
        logic [ADDR_WIDTH-1:0]   addr;
        logic [SWITCH_WIDTH-1:0] size_sw;
        bit                      write;
        for (int op = 0; op < count; op++) begin
            addr        = ADDR_WIDTH'($random(seed));
            addr[11:6]  = 6'h3f;  // Top 64 bytes, so bursts overlap and wrap
            size_sw     = SWITCH_WIDTH'($unsigned($random(seed)) % 11);
            write       = 1'($random(seed));
            if (write) begin
                fill_random();
                do_write(addr, size_sw);
            end else begin
                do_read(addr, size_sw);
            end
        end
    endtask

    task automatic report_test(input string name);
        int new_errors;
        new_errors = error_count - test_start_errors;
        tests_run++;
        if (new_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, new_errors);
        end
        test_start_errors = error_count;
    endtask

    initial begin
        int assert_fails;
        reset          = 1'b1;
        switches       = '0;
        enter          = 1'b0;
        check_armed    = 1'b0;
        check_expected = 8'h00;
        repeat (2) @(negedge clock);
        reset = 1'b0;

        fill_pattern(8'h31);
        do_write(27'h0000123, 10'd8);
        do_read(27'h0000123, 10'd8);
        report_test("write and read back");

        do_read(27'h0000700, 10'd8);
        report_test("unwritten location");

        fill_pattern(8'hc4);
        do_write({7'h2b, 10'h1c5, 10'h2f3}, 10'd5);
        do_read({7'h2b, 10'h1c5, 10'h2f3} ^ 27'h04a1000, 10'd5);  // Differs above bit 11
        report_test("address chunks and aliasing");

        fill_pattern(8'h5a);
        do_write(27'h0000300, 10'd0);  // One byte
        do_read(27'h0000300, 10'd2);
        fill_pattern(8'h17);
        do_write(27'h0000400, 10'd20);  // Clamped to a full burst
        do_read(27'h0000400, 10'd10);
        do_read(27'h0000408, 10'd1);
        fill_pattern(8'he8);
        do_write(27'h0000ffd, 10'd6);  // Crosses the top of memory
        do_read(27'h0000000, 10'd3);
        do_read(27'h0000ffd, 10'd6);
        report_test("size clamp and wrap");

        fill_pattern(8'h40);
        do_write(27'h0000200, 10'd8);
        fill_pattern(8'h90);
        do_write(27'h0000204, 10'd8);
        do_read(27'h0000200, 10'd8);
        do_read(27'h0000208, 10'd8);
        report_test("overlapping writes");

        random_ops(20);
        @(negedge clock);
        check("tester_idle", 32'(tester_idle), 32'd1);
        check("busy", 32'(busy), 32'd0);
        report_test("random operations");

        assert_fails = dut_i.uc_i.assertions_i.failure_count;
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: project.f
logic/sdram_tester_pkg.sv
logic/sdram_tester_uc.sv
logic/sdram_tester_df.sv
logic/burst_memory.sv
logic/sdram_tester.sv
verification/sdram_tester_assertions.sv
verification/sdram_tester_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module sdram_tester_tb -o sim

./obj_dir/sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation finished without failures"
